//--- bench/videoTb.sv
/*
 * Testbench for the rectangle video subsystem: clock, reset, host
 * writes, a reference model of each frame and a per-cycle compare
 */
`timescale 1ns/100ps
`default_nettype none

module videoTb;

	localparam int FRAME_CYCLES = videoPkg::H_TOTAL * videoPkg::V_TOTAL; // 420000
	localparam int NUM_FRAMES = 4;
	localparam int LATENCY = 3; // counters to rgb/sync pins
	localparam int TIMEOUT_CYCLES = FRAME_CYCLES * NUM_FRAMES * 11 / 10; // 10% margin
	localparam int ACK_WAIT_LIMIT = 16;

	logic clk;
	logic resetN;
	logic cfgReq;
	videoPkg::objIdxT cfgIdx;
	videoPkg::placeT cfgPos;
	logic cfgAck;
	logic hSync;
	logic vSync;
	videoPkg::colorT rgb;

	int benchCycle;   // linear index of the DUT counters since reset release
	int colorErrors;
	int syncErrors;
	int handshakeErrors;
	logic checkDone;
	int unsigned lcgState;
	videoPkg::placeT pending0; // model copy of what the host has written
	videoPkg::placeT pending1;
	videoPkg::placeT model0;   // positions in force for the frame being checked
	videoPkg::placeT model1;

	videoTop i_videoTop (
		.clk(clk),
		.resetN(resetN),
		.cfgReq(cfgReq),
		.cfgIdx(cfgIdx),
		.cfgPos(cfgPos),
		.cfgAck(cfgAck),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 25 MHz pixel clock
	end

	always @(posedge clk or negedge resetN) begin
		if (!resetN)
			benchCycle <= 0;
		else
			benchCycle <= benchCycle + 1;
	end

	function automatic int unsigned lcgNext(input int unsigned state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// position in -40..660, takes the upper bits of the LCG
	function automatic videoPkg::posT randomPos();
		int span;
		lcgState = lcgNext(lcgState);
		span = int'((lcgState >> 8) % 32'd701);
		return videoPkg::posT'(span - 40);
	endfunction

	function automatic videoPkg::placeT makePlace(input int x, input int y);
		videoPkg::placeT p;
		p.topLeftX = videoPkg::posT'(x);
		p.topLeftY = videoPkg::posT'(y);
		return p;
	endfunction

	function automatic logic hits(input int x, input int y, input videoPkg::placeT p,
		input int w, input int h);
		int left;
		int top;
		left = p.topLeftX; // sign extends
		top = p.topLeftY;
		return (x >= left) && (x < left + w) && (y >= top) && (y < top + h);
	endfunction

	// colour the screen should show at raster (x,y)
	function automatic videoPkg::colorT expectedPixel(input int x, input int y,
		input videoPkg::placeT p0, input videoPkg::placeT p1);
		int ox;
		int oy;
		if (x >= videoPkg::H_ACTIVE || y >= videoPkg::V_ACTIVE)
			return videoPkg::BACKGROUND; // blanking
		if (hits(x, y, p0, videoPkg::OBJ0_W, videoPkg::OBJ0_H)) begin
			ox = x - int'(p0.topLeftX);
			oy = y - int'(p0.topLeftY);
			if (ox == 0 || oy == 0 || ox == videoPkg::OBJ0_W - 1 || oy == videoPkg::OBJ0_H - 1)
				return videoPkg::FRAME_COLOR;
			return videoPkg::OBJ0_COLOR;
		end
		if (hits(x, y, p1, videoPkg::OBJ1_W, videoPkg::OBJ1_H))
			return videoPkg::OBJ1_COLOR;
		return videoPkg::BACKGROUND;
	endfunction

	// {hSync, vSync}, both active low
	function automatic logic [1:0] expectedSync(input int x, input int y);
		logic hs;
		logic vs;
		hs = !(x >= videoPkg::H_SYNC_START && x < videoPkg::H_SYNC_END);
		vs = !(y >= videoPkg::V_SYNC_START && y < videoPkg::V_SYNC_END);
		return {hs, vs};
	endfunction

	task automatic checkColor(input videoPkg::colorT got, input videoPkg::colorT exp,
		input int x, input int y);
		if (got !== exp) begin
			colorErrors++;
			$display("CHECK FAILED rgb at (%0d,%0d): got 'h%02h expected 'h%02h", x, y, got, exp);
		end
	endtask

	task automatic checkSync(input logic got, input logic exp, input string name,
		input int x, input int y);
		if (got !== exp) begin
			syncErrors++;
			$display("CHECK FAILED %s at (%0d,%0d): got 'h%0h expected 'h%0h", name, x, y, got, exp);
		end
	endtask

	task automatic checkAck(input logic got, input logic exp, input string when);
		if (got !== exp) begin
			handshakeErrors++;
			$display("CHECK FAILED cfgAck %s: got 'h%0h expected 'h%0h", when, got, exp);
		end
	endtask

	task automatic checkCycles(input int got, input int exp, input string name);
		if (got != exp) begin
			handshakeErrors++;
			$display("CHECK FAILED %s: got 'h%0h expected 'h%0h", name, got, exp);
		end
	endtask

	// returns 2 ns after the edge that starts the given line
	task automatic waitForLine(input int frame, input int line);
		int target;
		target = frame * FRAME_CYCLES + line * videoPkg::H_TOTAL;
		@(posedge clk);
		#2;
		while (benchCycle < target) begin
			@(posedge clk);
			#2;
		end
	endtask

	// four-phase write, req may be held high for a few extra cycles
	task automatic hostWrite(input videoPkg::objIdxT idx, input videoPkg::placeT pos,
		input int holdCycles);
		int waitCycles;
		checkAck(cfgAck, 1'b0, "before request");
		cfgIdx = idx;
		cfgPos = pos;
		cfgReq = 1'b1;
		if (idx == 1'b0)
			pending0 = pos;
		else
			pending1 = pos; // a second write simply replaces the first
		waitCycles = 0;
		while (cfgAck !== 1'b1 && waitCycles < ACK_WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			waitCycles++;
		end
		if (cfgAck !== 1'b1) begin
			handshakeErrors++;
			$display("ERROR: cfgAck never rose within %0d cycles of cfgReq", ACK_WAIT_LIMIT);
		end else begin
			checkCycles(waitCycles, 1, "ackRiseCycles");
		end
		repeat (holdCycles) begin
			@(posedge clk);
			#2;
			checkAck(cfgAck, 1'b1, "while cfgReq held");
		end
		cfgReq = 1'b0;
		waitCycles = 0;
		while (cfgAck !== 1'b0 && waitCycles < ACK_WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			waitCycles++;
		end
		if (cfgAck !== 1'b0) begin
			handshakeErrors++;
			$display("ERROR: cfgAck stayed high %0d cycles after cfgReq dropped", ACK_WAIT_LIMIT);
		end else begin
			checkCycles(waitCycles, 1, "ackFallCycles");
		end
	endtask

	task automatic reportCounts();
		$display("errors: color %0d, sync %0d, handshake %0d",
			colorErrors, syncErrors, handshakeErrors);
	endtask

	// compares every output cycle against the model, 3 clocks behind the counters
	initial begin : compareProcess
		int c;
		int x;
		int y;
		logic [1:0] syncExp;
		checkDone = 1'b0;
		wait (resetN === 1'b1);
		while (!checkDone) begin
			@(posedge clk);
			#10;
			if (benchCycle >= LATENCY) begin
				c = benchCycle - LATENCY;
				x = c % videoPkg::H_TOTAL;
				y = (c / videoPkg::H_TOTAL) % videoPkg::V_TOTAL;
				if (x == 0 && y == 0) begin
					model0 = pending0; // new frame takes the pending positions
					model1 = pending1;
				end
				checkColor(rgb, expectedPixel(x, y, model0, model1), x, y);
				syncExp = expectedSync(x, y);
				checkSync(hSync, syncExp[1], "hSync", x, y);
				checkSync(vSync, syncExp[0], "vSync", x, y);
				if (c == NUM_FRAMES * FRAME_CYCLES - 1)
					checkDone = 1'b1;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
		reportCounts();
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : stimulus
		resetN = 1'b0;
		cfgReq = 1'b0;
		cfgIdx = 1'b0;
		cfgPos = '0;
		colorErrors = 0;
		syncErrors = 0;
		handshakeErrors = 0;
		lcgState = 32'd53064;
		pending0 = videoPkg::OBJ0_RESET_POS;
		pending1 = videoPkg::OBJ1_RESET_POS;
		model0 = videoPkg::OBJ0_RESET_POS;
		model1 = videoPkg::OBJ1_RESET_POS;
		repeat (2) @(posedge clk);
		#2;
		// outputs while reset is held
		checkColor(rgb, videoPkg::BACKGROUND, 0, 0);
		checkSync(hSync, 1'b1, "hSync in reset", 0, 0);
		checkSync(vSync, 1'b1, "vSync in reset", 0, 0);
		checkAck(cfgAck, 1'b0, "in reset");
		resetN = 1'b1;

		waitForLine(0, 50); // frame 0 at reset positions, obj0 moves across obj1
		hostWrite(1'b0, makePlace(310, 190), 0);

		waitForLine(1, 50); // partial objects, off the top left and past the right edge
		hostWrite(1'b0, makePlace(-10, -12), 3);
		hostWrite(1'b1, makePlace(600, 470), 0);

		waitForLine(2, 50); // random positions for frame 3
		hostWrite(1'b0, makePlace(int'(randomPos()), int'(randomPos())), 0);
		hostWrite(1'b1, makePlace(int'(randomPos()), int'(randomPos())), 0);
		hostWrite(1'b0, makePlace(int'(randomPos()), int'(randomPos())), 1);

		wait (checkDone === 1'b1);
		reportCounts();
		if (colorErrors + syncErrors + handshakeErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
src/videoPkg.sv
src/vgaTiming.sv
src/squareObject.sv
src/placementRegs.sv
src/drawMux.sv
src/videoTop.sv
bench/videoTb.sv

//--- run.sh
#!/bin/sh
# build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module videoTb -o videoSim

./obj_dir/videoSim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported errors"
	exit 1
fi
echo "simulation finished without errors"

//--- src/drawMux.sv
/*
 * Draw mux: picks the pixel colour by priority (object 0 with its
 * border, object 1, background) and keeps sync aligned with rgb
 */
`timescale 1ns/100ps
`default_nettype none

module drawMux (
	input wire logic clk,
	input wire logic resetN,
	input videoPkg::rasterT raster,
	input videoPkg::drawT draw0,
	input videoPkg::drawT draw1,
	output logic hSync,
	output logic vSync,
	output videoPkg::colorT rgb
);

	logic hSyncD1; // first delay stage, aligned with draw0/draw1
	logic vSyncD1;
	logic activeD1;
	logic onBorder;
	videoPkg::colorT rgbNext;

	// one pixel frame around object 0
	assign onBorder = (draw0.offsetX == '0) || (draw0.offsetY == '0) ||
		(draw0.offsetX == videoPkg::coordT'(videoPkg::OBJ0_W - 1)) ||
		(draw0.offsetY == videoPkg::coordT'(videoPkg::OBJ0_H - 1));

	always_comb begin
		if (!activeD1)
			rgbNext = videoPkg::BACKGROUND; // blanking
		else if (draw0.drawingRequest)
			rgbNext = onBorder ? videoPkg::FRAME_COLOR : draw0.rgb;
		else if (draw1.drawingRequest)
			rgbNext = draw1.rgb;
		else
			rgbNext = videoPkg::BACKGROUND;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hSyncD1 <= 1'b1;
			vSyncD1 <= 1'b1;
			activeD1 <= 1'b0;
			hSync <= 1'b1; // second stage drives the pins
			vSync <= 1'b1;
			rgb <= videoPkg::BACKGROUND;
		end else begin
			hSyncD1 <= raster.hSync;
			vSyncD1 <= raster.vSync;
			activeD1 <= raster.active;
			hSync <= hSyncD1;
			vSync <= vSyncD1;
			rgb <= rgbNext;
		end
	end

endmodule

`default_nettype wire

//--- src/placementRegs.sv
/*
 * Object placement registers. A host writes a pending position over a
 * four-phase req/ack port; pending values go live at frame start
 */
`timescale 1ns/100ps
`default_nettype none

module placementRegs (
	input wire logic clk,
	input wire logic resetN,
	input wire logic frameStart,
	input wire logic cfgReq,
	input videoPkg::objIdxT cfgIdx,
	input videoPkg::placeT cfgPos,
	output logic cfgAck,
	output videoPkg::placeT place0,
	output videoPkg::placeT place1
);

	typedef enum logic {
		IDLE,  // waiting for cfgReq
		ACKED  // value taken, waiting for cfgReq to drop
	} hsStateT;

	hsStateT state;
	videoPkg::placeT pending0;
	videoPkg::placeT pending1;
	videoPkg::placeT active0;
	videoPkg::placeT active1;

	assign cfgAck = (state == ACKED);

	// handshake FSM and pending slots
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= IDLE;
			pending0 <= videoPkg::OBJ0_RESET_POS;
			pending1 <= videoPkg::OBJ1_RESET_POS;
		end else begin
			case (state)
				IDLE: if (cfgReq) begin
					if (cfgIdx == 1'b0)
						pending0 <= cfgPos; // a later write just overwrites
					else
						pending1 <= cfgPos;
					state <= ACKED;
				end
				ACKED: if (!cfgReq)
					state <= IDLE; // ack falls one clock after req drops
			endcase
		end
	end

	// pending becomes live at frame start
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			active0 <= videoPkg::OBJ0_RESET_POS;
			active1 <= videoPkg::OBJ1_RESET_POS;
		end else if (frameStart) begin
			active0 <= pending0;
			active1 <= pending1;
		end
	end

	// during the frameStart cycle the objects already see the new value,
	// so pixel (0,0) belongs to the new frame as well
	assign place0 = frameStart ? pending0 : active0;
	assign place1 = frameStart ? pending1 : active1;

endmodule

`default_nettype wire

//--- src/squareObject.sv
/*
 * Rectangle object: signed hit test of the current pixel against
 * the placed rectangle, registers request, colour and inner offsets
 */
`timescale 1ns/100ps
`default_nettype none

module squareObject #(
	parameter int OBJECT_WIDTH_X = 32,
	parameter int OBJECT_HEIGHT_Y = 32,
	parameter videoPkg::colorT OBJECT_COLOR = 8'h5B
) (
	input wire logic clk,
	input wire logic resetN,
	input videoPkg::rasterT raster,
	input videoPkg::placeT place,
	output videoPkg::drawT draw
);

	int pixX; // pixel as a plain int, zero extended
	int pixY;
	int leftX; // sign extended corner
	int topY;
	int rightX; // first column past the object
	int bottomY;
	logic insideBracket;

	always_comb begin
		pixX = int'(raster.pixelX);
		pixY = int'(raster.pixelY);
		leftX = int'(place.topLeftX);
		topY = int'(place.topLeftY);
		rightX = leftX + OBJECT_WIDTH_X;
		bottomY = topY + OBJECT_HEIGHT_Y;
		// half open on both axes
		insideBracket = (pixX >= leftX) && (pixX < rightX) &&
			(pixY >= topY) && (pixY < bottomY);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			draw <= '{drawingRequest: 1'b0, rgb: videoPkg::TRANSPARENT,
				offsetX: '0, offsetY: '0};
		end else if (insideBracket) begin
			draw.drawingRequest <= 1'b1;
			draw.rgb <= OBJECT_COLOR;
			draw.offsetX <= videoPkg::coordT'(pixX - leftX); // always in range inside
			draw.offsetY <= videoPkg::coordT'(pixY - topY);
		end else begin
			draw.drawingRequest <= 1'b0;
			draw.rgb <= videoPkg::TRANSPARENT; // never shown by the mux
			draw.offsetX <= '0;
			draw.offsetY <= '0;
		end
	end

endmodule

`default_nettype wire

//--- src/vgaTiming.sv
/*
 * VGA timing generator: pixel and line counters for 640x480,
 * registered coordinates, sync pulses, active window and frame start
 */
`timescale 1ns/100ps
`default_nettype none

module vgaTiming (
	input wire logic clk,
	input wire logic resetN,
	output videoPkg::rasterT raster
);

	videoPkg::coordT pixelCnt; // horizontal counter
	videoPkg::coordT lineCnt;  // vertical counter
	logic lineEnd;
	logic frameEnd;
	logic hSyncNext;
	logic vSyncNext;
	logic activeNext;

	assign lineEnd = (pixelCnt == videoPkg::coordT'(videoPkg::H_TOTAL - 1));
	assign frameEnd = (lineCnt == videoPkg::coordT'(videoPkg::V_TOTAL - 1));

	// decodes from the counters, registered below with the coordinates
	always_comb begin
		hSyncNext = !((pixelCnt >= videoPkg::coordT'(videoPkg::H_SYNC_START)) &&
			(pixelCnt < videoPkg::coordT'(videoPkg::H_SYNC_END))); // low in the sync window
		vSyncNext = !((lineCnt >= videoPkg::coordT'(videoPkg::V_SYNC_START)) &&
			(lineCnt < videoPkg::coordT'(videoPkg::V_SYNC_END)));
		activeNext = (pixelCnt < videoPkg::coordT'(videoPkg::H_ACTIVE)) &&
			(lineCnt < videoPkg::coordT'(videoPkg::V_ACTIVE));
	end

	// free running counters, never stall
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixelCnt <= '0;
			lineCnt <= '0;
		end else begin
			if (lineEnd) begin
				pixelCnt <= '0;
				if (frameEnd)
					lineCnt <= '0; // wrap at V_TOTAL
				else
					lineCnt <= lineCnt + 1'b1;
			end else begin
				pixelCnt <= pixelCnt + 1'b1;
			end
		end
	end

	// raster is one clock behind the counters
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			raster.pixelX <= '0;
			raster.pixelY <= '0;
			raster.hSync <= 1'b1; // inactive
			raster.vSync <= 1'b1;
			raster.active <= 1'b0;
			raster.frameStart <= 1'b0;
		end else begin
			raster.pixelX <= pixelCnt;
			raster.pixelY <= lineCnt;
			raster.hSync <= hSyncNext;
			raster.vSync <= vSyncNext;
			raster.active <= activeNext;
			raster.frameStart <= (pixelCnt == '0) && (lineCnt == '0);
		end
	end

endmodule

`default_nettype wire

//--- src/videoPkg.sv
/*
 * Video package: raster timing for 640x480 VGA, object defaults,
 * colour encodings and the types shared by the rectangle subsystem
 */
`default_nettype none

package videoPkg;

	typedef logic [10:0] coordT;        // unsigned screen coordinate or offset
	typedef logic signed [10:0] posT;   // signed so objects can start off-screen
	typedef logic [7:0] colorT;         // RGB332
	typedef logic objIdxT;              // object select on the host port

	typedef struct packed {
		coordT pixelX;
		coordT pixelY;
		logic hSync;      // active low
		logic vSync;      // active low
		logic active;
		logic frameStart; // one cycle at (0,0)
	} rasterT;

	typedef struct packed {
		posT topLeftX;
		posT topLeftY;
	} placeT;

	typedef struct packed {
		logic drawingRequest;
		colorT rgb;
		coordT offsetX; // offset from the top-left corner
		coordT offsetY;
	} drawT;

	// horizontal timing in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_TOTAL = 800;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT; // 656
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC; // 752

	// vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 525;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT; // 490
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC; // 492

	localparam colorT TRANSPARENT = 8'hFF;
	localparam colorT BACKGROUND = 8'h00;
	localparam colorT FRAME_COLOR = 8'hFC; // yellow border of object 0

	localparam int OBJ0_W = 32;
	localparam int OBJ0_H = 32;
	localparam colorT OBJ0_COLOR = 8'h5B;
	localparam int OBJ1_W = 64;
	localparam int OBJ1_H = 16;
	localparam colorT OBJ1_COLOR = 8'hE0;

	localparam placeT OBJ0_RESET_POS = '{topLeftX: 11'sd100, topLeftY: 11'sd100};
	localparam placeT OBJ1_RESET_POS = '{topLeftX: 11'sd300, topLeftY: 11'sd200};

endpackage

`default_nettype wire

//--- src/videoTop.sv
/*
 * Video top level: timing generator, placement registers,
 * two rectangle objects and the draw mux
 */
`timescale 1ns/100ps
`default_nettype none

module videoTop (
	input wire logic clk,
	input wire logic resetN,
	input wire logic cfgReq,
	input videoPkg::objIdxT cfgIdx,
	input videoPkg::placeT cfgPos,
	output logic cfgAck,
	output logic hSync,
	output logic vSync,
	output videoPkg::colorT rgb
);

	videoPkg::rasterT raster;
	videoPkg::placeT place0;
	videoPkg::placeT place1;
	videoPkg::drawT draw0;
	videoPkg::drawT draw1;

	vgaTiming i_vgaTiming (
		.clk(clk),
		.resetN(resetN),
		.raster(raster)
	);

	placementRegs i_placementRegs (
		.clk(clk),
		.resetN(resetN),
		.frameStart(raster.frameStart),
		.cfgReq(cfgReq),
		.cfgIdx(cfgIdx),
		.cfgPos(cfgPos),
		.cfgAck(cfgAck),
		.place0(place0),
		.place1(place1)
	);

	// object 0, square with border, highest priority
	squareObject #(
		.OBJECT_WIDTH_X(videoPkg::OBJ0_W),
		.OBJECT_HEIGHT_Y(videoPkg::OBJ0_H),
		.OBJECT_COLOR(videoPkg::OBJ0_COLOR)
	) i_obj0 (
		.clk(clk),
		.resetN(resetN),
		.raster(raster),
		.place(place0),
		.draw(draw0)
	);

	// object 1, wide bar
	squareObject #(
		.OBJECT_WIDTH_X(videoPkg::OBJ1_W),
		.OBJECT_HEIGHT_Y(videoPkg::OBJ1_H),
		.OBJECT_COLOR(videoPkg::OBJ1_COLOR)
	) i_obj1 (
		.clk(clk),
		.resetN(resetN),
		.raster(raster),
		.place(place1),
		.draw(draw1)
	);

	drawMux i_drawMux (
		.clk(clk),
		.resetN(resetN),
		.raster(raster),
		.draw0(draw0),
		.draw1(draw1),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

endmodule

`default_nettype wire
